/* hdl/msx_params.svh */
`ifndef MSX_PARAMS_SVH
`define MSX_PARAMS_SVH

// Primary slots behind the PPI port A selector
`define MSX_NUM_SLOTS 4

// Page index comes from address bits 15:14
`define MSX_PAGE_BITS 2

// Slot memory address is {page, addr[7:0]}
// Address bits 13:8 alias inside a page
`define MSX_SLOT_AW 10

// 8255 PPI occupies ports A8..AB
`define MSX_PPI_BASE 8'hA8

`endif

/* hdl/msx_pkg.sv */
`default_nettype none

package msx_pkg;

   // M1 wait generator states
   // W_WAIT is the single inserted wait T-state
   typedef enum logic [1:0] {
      W_IDLE = 2'd0,
      W_WAIT = 2'd1,
      W_HOLD = 2'd2
   } wait_state_t;

   // Source of an I/O read
   // IO_NONE means no PPI port answers this cycle
   typedef enum logic [1:0] {
      IO_NONE  = 2'd0,
      IO_PPI_A = 2'd1,
      IO_PPI_B = 2'd2,
      IO_PPI_C = 2'd3
   } io_dev_t;

endpackage

`default_nettype wire

/* hdl/m1_wait_gen.sv */
`default_nettype none

module m1_wait_gen
   import msx_pkg::*;
(
   input  logic clk21m,
   input  logic exwait_n,
   input  logic ce_3m58_p,
   input  logic m1_n,
   output logic wait_n
);

   wait_state_t state;
   wait_state_t state_next;

   // wait_n as seen at the previous CPU clock pulse
   logic        last_ce_wait_n;

   // One wait T-state per opcode fetch, stepped on the 3.58 MHz enable
   always_comb begin
      state_next = state;
      case (state)
         W_IDLE: begin
            if (!m1_n) begin
               state_next = W_WAIT;
            end
         end
         W_WAIT: begin
            state_next = W_HOLD;
         end
         W_HOLD: begin
            // Stay here until the fetch ends
            if (m1_n) begin
               state_next = W_IDLE;
            end
         end
         default: begin
            state_next = W_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         state <= W_IDLE;
      end else if (ce_3m58_p) begin
         state <= state_next;
      end
   end

   // Low for exactly one enable period
   assign wait_n = (state != W_WAIT);

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         last_ce_wait_n <= 1'b1;
      end else if (ce_3m58_p) begin
         last_ce_wait_n <= wait_n;
      end
   end

   // Never two wait T-states in a row
   a_single_wait: assert property (
      @(posedge clk21m) disable iff (!exwait_n)
      (ce_3m58_p && !wait_n) |-> last_ce_wait_n
   ) else $error("wait_n low at two consecutive CPU clock pulses");

endmodule

`default_nettype wire

/* hdl/ppi_regs.sv */
`default_nettype none

module ppi_regs
   import msx_pkg::*;
(
   input  logic       clk21m,
   input  logic       exwait_n,
   input  logic [7:0] addr,
   input  logic [7:0] din,
   input  logic       iorq_n,
   input  logic       m1_n,
   input  logic       rd_n,
   input  logic       wr_n,
   input  logic [7:0] kb_data,
   output logic [7:0] port_a,
   output logic [7:0] port_c,
   output logic       map_valid,
   output io_dev_t    rd_dev,
   output logic [7:0] ppi_data
);

`include "msx_params.svh"

   localparam logic [7:0] PPI_BASE = `MSX_PPI_BASE;

   logic io_cycle;
   logic ppi_hit;
   logic ppi_wr;
   logic ppi_rd;

   // Interrupt acknowledge also pulls iorq_n, so M1 must be high
   assign io_cycle = !iorq_n && m1_n;
   assign ppi_hit  = io_cycle && (addr[7:2] == PPI_BASE[7:2]);
   assign ppi_wr   = ppi_hit && !wr_n;
   assign ppi_rd   = ppi_hit && !rd_n;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         port_a    <= 8'h00;
         port_c    <= 8'h00;
         map_valid <= 1'b0;
      end else if (ppi_wr) begin
         // Slot map is undefined until software touches the PPI
         map_valid <= 1'b1;
         case (addr[1:0])
            2'd0: begin
               port_a <= din;
            end
            2'd2: begin
               port_c <= din;
            end
            2'd3: begin
               // Bit 7 set is a mode word, no effect here
               if (!din[7]) begin
                  port_c[din[3:1]] <= din[0];
               end
            end
            default: begin
               // Port B is input only
            end
         endcase
      end
   end

   // Read decode, control port is write only
   always_comb begin
      rd_dev = IO_NONE;
      if (ppi_rd) begin
         case (addr[1:0])
            2'd0:    rd_dev = IO_PPI_A;
            2'd1:    rd_dev = IO_PPI_B;
            2'd2:    rd_dev = IO_PPI_C;
            default: rd_dev = IO_NONE;
         endcase
      end
   end

   always_comb begin
      case (rd_dev)
         IO_PPI_A: ppi_data = port_a;
         IO_PPI_B: ppi_data = kb_data;
         IO_PPI_C: ppi_data = port_c;
         default:  ppi_data = 8'hFF;
      endcase
   end

   a_io_rd_wr_excl: assert property (
      @(posedge clk21m) disable iff (!exwait_n)
      io_cycle |-> (rd_n || wr_n)
   ) else $error("rd_n and wr_n both low in an I/O cycle");

endmodule

`default_nettype wire

/* hdl/slot_decoder.sv */
`default_nettype none

`include "msx_params.svh"

module slot_decoder
   import msx_pkg::*;
(
   input  logic [`MSX_PAGE_BITS-1:0] addr_page,
   input  logic [7:0]                port_a,
   input  logic                      map_valid,
   input  logic                      mreq_n,
   output logic [`MSX_NUM_SLOTS-1:0] slot_sel
);

   logic [1:0] active_slot;

   // Two bits of port A per page, page 0 in the low bits
   // Before the first PPI write everything sits in slot 0
   always_comb begin
      if (map_valid) begin
         active_slot = port_a[{addr_page, 1'b0} +: 2];
      end else begin
         active_slot = 2'b00;
      end
   end

   // One-hot select, only during a memory request
   always_comb begin
      for (int i = 0; i < `MSX_NUM_SLOTS; i++) begin
         slot_sel[i] = !mreq_n && (int'(active_slot) == i);
      end
   end

   always_comb begin
      a_sel_onehot: assert ($onehot0(slot_sel))
         else $error("slot_sel not one-hot: %b", slot_sel);
   end

endmodule

`default_nettype wire

/* hdl/slot_memory.sv */
`default_nettype none

`include "msx_params.svh"

module slot_memory
   import msx_pkg::*;
(
   input  logic                    clk21m,
   input  logic [`MSX_SLOT_AW-1:0] mem_addr,
   input  logic [7:0]              din,
   input  logic                    sel,
   input  logic                    wr_n,
   output logic [7:0]              rdata
);

   localparam int DEPTH = 1 << `MSX_SLOT_AW;

   // 256 bytes per page, four pages per slot
   logic [7:0] mem [0:DEPTH-1];

   // Write lands on every edge while the strobe is held
   always_ff @(posedge clk21m) begin
      if (sel && !wr_n) begin
         mem[mem_addr] <= din;
      end
   end

   // Async read, the mux decides who drives the CPU
   assign rdata = mem[mem_addr];

endmodule

`default_nettype wire

/* hdl/cpu_data_mux.sv */
`default_nettype none

`include "msx_params.svh"

module cpu_data_mux
   import msx_pkg::*;
(
   input  logic                           rd_n,
   input  io_dev_t                        rd_dev,
   input  logic [7:0]                     ppi_data,
   input  logic [`MSX_NUM_SLOTS-1:0]      slot_sel,
   input  logic [`MSX_NUM_SLOTS-1:0][7:0] slot_data,
   output logic [7:0]                     dout
);

   logic [7:0] slot_byte;
   logic       mem_rd;

   // Unselected slots contribute zero
   always_comb begin
      slot_byte = 8'h00;
      for (int i = 0; i < `MSX_NUM_SLOTS; i++) begin
         slot_byte = slot_byte | (slot_data[i] & {8{slot_sel[i]}});
      end
   end

   assign mem_rd = |slot_sel;

   // Open bus reads as FF
   always_comb begin
      if (rd_n) begin
         dout = 8'hFF;
      end else if (rd_dev != IO_NONE) begin
         dout = ppi_data;
      end else if (mem_rd) begin
         dout = slot_byte;
      end else begin
         dout = 8'hFF;
      end
   end

endmodule

`default_nettype wire

/* hdl/msx_bus_core.sv */
`default_nettype none

module msx_bus_core
   import msx_pkg::*;
(
   input  logic        clk21m,
   input  logic        exwait_n,
   input  logic        ce_3m58_p,
   // Z80 bus
   input  logic [15:0] addr,
   input  logic [7:0]  din,
   input  logic        mreq_n,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic        m1_n,
   output logic [7:0]  dout,
   output logic        wait_n,
   // Keyboard and cassette
   input  logic [7:0]  kb_data,
   output logic        cas_motor,
   output logic        keybeep,
   output logic [3:0]  kb_row
);

`include "msx_params.svh"

   logic [7:0]                     port_a;
   logic [7:0]                     port_c;
   logic                           map_valid;
   io_dev_t                        rd_dev;
   logic [7:0]                     ppi_data;
   logic [`MSX_NUM_SLOTS-1:0]      slot_sel;
   logic [`MSX_NUM_SLOTS-1:0][7:0] slot_data;

   m1_wait_gen u_m1_wait (
      .clk21m    (clk21m),
      .exwait_n  (exwait_n),
      .ce_3m58_p (ce_3m58_p),
      .m1_n      (m1_n),
      .wait_n    (wait_n)
   );

   ppi_regs u_ppi (
      .clk21m    (clk21m),
      .exwait_n  (exwait_n),
      .addr      (addr[7:0]),
      .din       (din),
      .iorq_n    (iorq_n),
      .m1_n      (m1_n),
      .rd_n      (rd_n),
      .wr_n      (wr_n),
      .kb_data   (kb_data),
      .port_a    (port_a),
      .port_c    (port_c),
      .map_valid (map_valid),
      .rd_dev    (rd_dev),
      .ppi_data  (ppi_data)
   );

   slot_decoder u_slot_dec (
      .addr_page (addr[15:14]),
      .port_a    (port_a),
      .map_valid (map_valid),
      .mreq_n    (mreq_n),
      .slot_sel  (slot_sel)
   );

   // Primary slots, each with its own backing store
   for (genvar i = 0; i < `MSX_NUM_SLOTS; i++) begin : g_slot
      slot_memory u_mem (
         .clk21m   (clk21m),
         .mem_addr ({addr[15:14], addr[7:0]}),
         .din      (din),
         .sel      (slot_sel[i]),
         .wr_n     (wr_n),
         .rdata    (slot_data[i])
      );
   end

   cpu_data_mux u_data_mux (
      .rd_n      (rd_n),
      .rd_dev    (rd_dev),
      .ppi_data  (ppi_data),
      .slot_sel  (slot_sel),
      .slot_data (slot_data),
      .dout      (dout)
   );

   // PPI port C pins
   assign kb_row    = port_c[3:0];
   assign cas_motor = port_c[4];
   assign keybeep   = port_c[7];

endmodule

`default_nettype wire

/* tests/tb_msx_bus_core.sv */
`default_nettype none

module tb_msx_bus_core
   import msx_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

`include "msx_params.svh"

   localparam int WAIT_LIMIT = 40;

   logic        clk21m;
   logic        exwait_n;
   logic        ce_3m58_p;
   logic [15:0] addr;
   logic [7:0]  din;
   logic        mreq_n;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   logic        m1_n;
   logic [7:0]  kb_data;
   logic [7:0]  dout;
   logic        wait_n;
   logic        cas_motor;
   logic        keybeep;
   logic [3:0]  kb_row;

   int          seed;
   int          records;
   // Expected slot contents after the random fill
   logic [7:0]  model [0:`MSX_NUM_SLOTS-1][0:(1 << `MSX_SLOT_AW)-1];

   msx_bus_core UUT (
      .clk21m    (clk21m),
      .exwait_n  (exwait_n),
      .ce_3m58_p (ce_3m58_p),
      .addr      (addr),
      .din       (din),
      .mreq_n    (mreq_n),
      .iorq_n    (iorq_n),
      .rd_n      (rd_n),
      .wr_n      (wr_n),
      .m1_n      (m1_n),
      .dout      (dout),
      .wait_n    (wait_n),
      .kb_data   (kb_data),
      .cas_motor (cas_motor),
      .keybeep   (keybeep),
      .kb_row    (kb_row)
   );

   initial begin
      clk21m = 1'b0;
      forever #10 clk21m = ~clk21m;
   end

   // CPU clock enable, one pulse every 6 clocks
   initial begin : ce_gen
      int ce_cnt;
      ce_cnt    = 0;
      ce_3m58_p = 1'b0;
      forever begin
         @(posedge clk21m);
         ce_cnt = (ce_cnt == 5) ? 0 : ce_cnt + 1;
         ce_3m58_p <= (ce_cnt == 5);
      end
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("Fail at %0d ns: %s gave %02h, expected %02h",
                             $time, what, got, exp));
      end
   endtask

   task automatic check_ctrl(input logic [3:0] row_got, input logic motor_got,
                             input logic beep_got, input logic [3:0] row_exp,
                             input logic motor_exp, input logic beep_exp);
      if ({row_got, motor_got, beep_got} !== {row_exp, motor_exp, beep_exp}) begin
         abort_run($sformatf("Fail at %0d ns: row %h motor %b beep %b, expected %h %b %b",
                             $time, row_got, motor_got, beep_got,
                             row_exp, motor_exp, beep_exp));
      end
   endtask

   task automatic check_wait(input int got, input int exp);
      wait_state_t ws;
      ws = W_WAIT;
      if (got != exp) begin
         abort_run($sformatf("Fail at %0d ns: %s lasted %0d cycles, expected %0d",
                             $time, ws.name(), got, exp));
      end
   endtask

   // One bus cycle, strobes low for a single clock
   task automatic bus_cycle(input logic is_io, input logic is_wr, input logic [15:0] a,
                            input logic [7:0] d, output logic [7:0] q);
      @(posedge clk21m);
      addr   <= a;
      din    <= d;
      mreq_n <= is_io;
      iorq_n <= !is_io;
      rd_n   <= is_wr;
      wr_n   <= !is_wr;
      @(negedge clk21m);
      q = dout;
      @(posedge clk21m);
      mreq_n <= 1'b1;
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      wr_n   <= 1'b1;
   endtask

   // Opcode fetch held until the wait state is over
   task automatic m1_fetch(input logic [15:0] a, input logic [7:0] exp_op, input int exp_len);
      int n;
      int low;
      @(posedge clk21m);
      addr   <= a;
      mreq_n <= 1'b0;
      rd_n   <= 1'b0;
      m1_n   <= 1'b0;
      n = 0;
      @(negedge clk21m);
      while (wait_n && n < WAIT_LIMIT) begin
         @(negedge clk21m);
         n++;
      end
      if (wait_n) abort_run("Timed out waiting for wait_n to drop in an M1 fetch");
      low = 0;
      while (!wait_n && low < WAIT_LIMIT) begin
         low++;
         @(negedge clk21m);
      end
      if (!wait_n) abort_run("Timed out waiting for wait_n to rise in an M1 fetch");
      check_wait(low, exp_len);
      check_byte($sformatf("opcode fetch at %04h", a), dout, exp_op);
      @(posedge clk21m);
      mreq_n <= 1'b1;
      rd_n   <= 1'b1;
      m1_n   <= 1'b1;
      // Long enough for one enable pulse to see m1_n high
      for (int i = 0; i < 8; i++) begin
         @(negedge clk21m);
         if (!wait_n) abort_run("wait_n went low between M1 fetches");
      end
   endtask

   task automatic fill_and_verify(input int rounds);
      logic [7:0]  map;
      logic [7:0]  base;
      logic [7:0]  b;
      logic [7:0]  q;
      logic [15:0] a;
      // Rotated maps so every page lands in every slot once
      for (int r = 0; r < `MSX_NUM_SLOTS; r++) begin
         for (int p = 0; p < `MSX_NUM_SLOTS; p++) begin
            map[2*p +: 2] = 2'(p + r);
         end
         bus_cycle(1'b1, 1'b1, {8'h00, `MSX_PPI_BASE}, map, q);
         for (int p = 0; p < `MSX_NUM_SLOTS; p++) begin
            for (int o = 0; o < 256; o++) begin
               b = 8'($random(seed));
               a = {2'(p), 6'($random(seed)), 8'(o)};
               model[map[2*p +: 2]][{2'(p), 8'(o)}] = b;
               bus_cycle(1'b0, 1'b1, a, b, q);
            end
         end
      end
      for (int k = 0; k < rounds; k++) begin
         base = 8'($random(seed));
         for (int r = 0; r < `MSX_NUM_SLOTS; r++) begin
            for (int p = 0; p < `MSX_NUM_SLOTS; p++) begin
               map[2*p +: 2] = base[2*p +: 2] + 2'(r);
            end
            bus_cycle(1'b1, 1'b1, {8'h00, `MSX_PPI_BASE}, map, q);
            for (int p = 0; p < `MSX_NUM_SLOTS; p++) begin
               for (int o = 0; o < 256; o++) begin
                  a = {2'(p), 6'($random(seed)), 8'(o)};
                  bus_cycle(1'b0, 1'b0, a, 8'h00, q);
                  check_byte($sformatf("slot %0d read at %04h", map[2*p +: 2], a),
                             q, model[map[2*p +: 2]][{2'(p), 8'(o)}]);
               end
            end
         end
      end
   endtask

   task automatic need_fields(input int got, input int want, input logic [7:0] op);
      if (got != want) abort_run($sformatf("Trace record '%s' has missing fields", op));
   endtask

   task automatic skip_line(input int fd);
      int c;
      c = $fgetc(fd);
      while (c != 10 && c != -1) c = $fgetc(fd);
   endtask

   task automatic run_record(input int fd, input logic [7:0] op);
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      logic [7:0]  q;
      int          n;
      case (op)
         "W": begin
            n = $fscanf(fd, "%h %h", f1, f2);
            need_fields(n, 2, op);
            bus_cycle(1'b0, 1'b1, f1[15:0], f2[7:0], q);
         end
         "R": begin
            n = $fscanf(fd, "%h %h", f1, f2);
            need_fields(n, 2, op);
            bus_cycle(1'b0, 1'b0, f1[15:0], 8'h00, q);
            check_byte($sformatf("memory read at %04h", f1[15:0]), q, f2[7:0]);
         end
         "O": begin
            n = $fscanf(fd, "%h %h", f1, f2);
            need_fields(n, 2, op);
            bus_cycle(1'b1, 1'b1, {8'h00, f1[7:0]}, f2[7:0], q);
         end
         "I": begin
            n = $fscanf(fd, "%h %h", f1, f2);
            need_fields(n, 2, op);
            bus_cycle(1'b1, 1'b0, {8'h00, f1[7:0]}, 8'h00, q);
            check_byte($sformatf("I/O read of port %02h", f1[7:0]), q, f2[7:0]);
         end
         "K": begin
            n = $fscanf(fd, "%h", f1);
            need_fields(n, 1, op);
            @(posedge clk21m);
            kb_data <= f1[7:0];
         end
         "C": begin
            n = $fscanf(fd, "%h %h %h", f1, f2, f3);
            need_fields(n, 3, op);
            @(negedge clk21m);
            check_ctrl(kb_row, cas_motor, keybeep, f1[3:0], f2[0], f3[0]);
         end
         "M": begin
            n = $fscanf(fd, "%h %h %h", f1, f2, f3);
            need_fields(n, 3, op);
            m1_fetch(f1[15:0], f2[7:0], int'(f3));
         end
         "F": begin
            n = $fscanf(fd, "%h", f1);
            need_fields(n, 1, op);
            fill_and_verify(int'(f1));
         end
         default: abort_run($sformatf("Unknown trace record type '%s'", op));
      endcase
      records++;
   endtask

   initial begin
      int         fd;
      int         n;
      logic [7:0] op;
      seed     = 32'h78448006;
      records  = 0;
      exwait_n = 1'b0;
      addr     = 16'h0000;
      din      = 8'h00;
      mreq_n   = 1'b1;
      iorq_n   = 1'b1;
      rd_n     = 1'b1;
      wr_n     = 1'b1;
      m1_n     = 1'b1;
      kb_data  = 8'hFF;
      repeat (10) @(posedge clk21m);
      exwait_n <= 1'b1;
      @(negedge clk21m);
      if (!wait_n) abort_run("wait_n is low after reset");
      fd = $fopen("tests/msx_bus_trace.txt", "r");
      if (fd == 0) abort_run("Cannot open the trace file tests/msx_bus_trace.txt");
      n = $fscanf(fd, "%s", op);
      while (n == 1) begin
         if (op == "#") skip_line(fd);
         else run_record(fd, op);
         n = $fscanf(fd, "%s", op);
      end
      $fclose(fd);
      if (records > 0) begin
         $display(">>> PASS");
         $finish;
      end else begin
         abort_run("The trace file holds no records");
      end
   end

endmodule

`default_nettype wire

/* tests/msx_bus_trace.txt */
# Op then hex fields. W/R addr data, O/I port data, K kb_data,
# C kb_row cas_motor keybeep, M addr opcode wait_cycles, F verify_rounds
W 8012 5A
R 8012 5A
R BF12 5A
W 0034 11
W C034 33
R C034 33
# Page p in slot p
O A8 E4
I A8 E4
W 0050 A0
W 4050 A1
W C050 A3
# Same offset of page 2 in different slots
O A8 00
W 8060 B0
O A8 10
W 8060 B1
O A8 30
W 8060 B3
O A8 00
R 8060 B0
R 8012 5A
R 0034 11
O A8 30
R 8060 B3
O A8 10
R 8060 B1
O A8 E4
R 4050 A1
# Port C pins, bit set and reset, mode word
O AA 95
C 5 1 1
O AB 08
C 5 0 1
O AB 0E
O AB 03
O AB 09
O AB 9B
C 7 1 0
I AA 17
I AB FF
K 3C
I A9 3C
I 98 FF
M 4050 A1 6
M C050 A3 6
M 0050 A0 6
F 2

/* verilog.f */
+incdir+hdl
hdl/msx_pkg.sv
hdl/m1_wait_gen.sv
hdl/ppi_regs.sv
hdl/slot_decoder.sv
hdl/slot_memory.sv
hdl/cpu_data_mux.sv
hdl/msx_bus_core.sv
tests/tb_msx_bus_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_msx_bus_core
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE) -j 0
LINTFLAGS ?= --lint-only --timing --assert --timescale $(TIMESCALE)

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$($(SIM) 2>&1)"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qxF -- '>>> PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
